//--- hdl/ems_mapper.sv
/*
 * EMS page mapper
 * Four page-map registers at 260h..263h and the memory window
 * hit outputs for the selected page frame
 */
`timescale 1ns/1ps

module ems_mapper
    import xt_io_pkg::*;
(
    input  logic                    clock,
    input  logic                    reset,
    input  bus_req_t                bus_i,
    input  dev_sel_t                sel_i,
    input  logic [1:0]              ems_frame_i,
    output ems_map_t [EMS_PAGES-1:0] maps_o,
    output logic [EMS_PAGES-1:0]    ems_hit_o
);

    ems_action_e action;
    ems_map_t    new_entry;
    logic [1:0]  wr_index;
    ems_action_e wr_action;
    ems_map_t    wr_entry;
    logic        wr_en;
    logic [3:0]  frame;
    logic        mem_cycle;

    // Classify the write byte
    always_comb begin
        if (bus_i.data == IDLE_BYTE) begin
            action    = EMS_UNMAP;
            new_entry = '{enable: 1'b0, page: IDLE_BYTE[EMS_MAP_W-1:0]};
        end
        else if (~bus_i.data[DATA_W-1]) begin
            action    = EMS_MAP;
            new_entry = '{enable: 1'b1, page: bus_i.data[EMS_MAP_W-1:0]};
        end
        else begin
            action    = EMS_KEEP;
            new_entry = maps_o[bus_i.address[1:0]];
        end
    end

    // First stage: capture the write request
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            wr_en     <= 1'b0;
            wr_action <= EMS_KEEP;
        end
        else begin
            wr_en     <= sel_i.ems & ~bus_i.io_write_n;
            wr_action <= action;
        end
    end

    always_ff @(posedge clock) begin
        wr_index <= bus_i.address[1:0];
        wr_entry <= new_entry;
    end

    // Second stage: update the map entry
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            maps_o <= '0;
        end
        else if (wr_en && wr_action != EMS_KEEP) begin
            maps_o[wr_index] <= wr_entry;
        end
    end

    always_comb begin
        case (ems_frame_i)
            2'd0:    frame = EMS_FRAME_A;
            2'd1:    frame = EMS_FRAME_C;
            default: frame = EMS_FRAME_D;
        endcase
    end

    assign mem_cycle = bus_i.io_read_n & bus_i.io_write_n;

    // 16 KB windows inside the 64 KB frame
    for (genvar n = 0; n < EMS_PAGES; n++) begin : g_hit
        assign ems_hit_o[n] = mem_cycle & maps_o[n].enable
                            & (bus_i.address[ADDR_W-1:14] == {frame, 2'(n)});
    end

endmodule

//--- hdl/io_decode.sv
/*
 * I/O address decoder
 * Maps the ISA port address to internal device selects and
 * the active-low chip selects of the on-board peripherals
 */
`timescale 1ns/1ps

module io_decode
    import xt_io_pkg::*;
(
    input  bus_req_t bus_i,
    input  logic     ems_enabled_i,
    input  logic     tandy_video_i,
    output dev_sel_t sel_o,
    output logic     dma_cs_n_o,
    output logic     dma_page_cs_n_o,
    output logic     pic_cs_n_o,
    output logic     pit_cs_n_o,
    output logic     ppi_cs_n_o
);

    logic       io_cycle;
    logic       io_qual;
    logic       xt_block;
    logic [2:0] block;
    logic       dma_hit;
    logic       dma_page_hit;
    logic       pic_hit;
    logic       pit_hit;
    logic       ppi_hit;

    assign io_cycle = ~bus_i.io_read_n | ~bus_i.io_write_n;
    assign io_qual  = io_cycle & ~bus_i.address_enable_n;

    // First 256 ports are split into 32-byte blocks
    assign xt_block = io_qual & (bus_i.address[9:8] == 2'b00);
    assign block    = bus_i.address[7:5];

    always_comb begin
        dma_hit      = 1'b0;
        pic_hit      = 1'b0;
        pit_hit      = 1'b0;
        ppi_hit      = 1'b0;
        dma_page_hit = 1'b0;
        if (xt_block) begin
            case (block)
                3'd0: dma_hit = 1'b1;
                3'd1: pic_hit = 1'b1;
                3'd2: pit_hit = 1'b1;
                3'd3: ppi_hit = 1'b1;
                3'd4: dma_page_hit = 1'b1;
                default: ;
            endcase
        end
    end

    always_comb begin
        sel_o.pic = pic_hit;
        sel_o.pit = pit_hit;
        sel_o.ppi = ppi_hit;

        // 260h..263h
        sel_o.ems = io_qual & ems_enabled_i
                  & (bus_i.address[15:2] == EMS_PORT_BASE[15:2]);

        sel_o.lpt = io_qual & (bus_i.address[15:0] == LPT_PORT);

        // A0h..A7h, Tandy only
        sel_o.nmi_mask = io_qual & tandy_video_i
                       & (bus_i.address[15:3] == NMI_PORT_BASE[15:3]);
    end

    assign dma_cs_n_o      = ~dma_hit;
    assign dma_page_cs_n_o = ~dma_page_hit;
    assign pic_cs_n_o      = ~pic_hit;
    assign pit_cs_n_o      = ~pit_hit;
    assign ppi_cs_n_o      = ~ppi_hit;

endmodule

//--- hdl/port_latches.sv
/*
 * Port latches
 * Printer data latch at 378h and Tandy NMI mask at A0h..A7h
 */
`timescale 1ns/1ps

module port_latches
    import xt_io_pkg::*;
(
    input  logic              clock,
    input  logic              reset,
    input  bus_req_t          bus_i,
    input  dev_sel_t          sel_i,
    output logic [DATA_W-1:0] lpt_data_o,
    output logic [DATA_W-1:0] nmi_mask_o
);

    logic lpt_write;
    logic nmi_write;

    assign lpt_write = sel_i.lpt & ~bus_i.io_write_n;
    assign nmi_write = sel_i.nmi_mask & ~bus_i.io_write_n;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            lpt_data_o <= LPT_RESET;
        end
        else if (lpt_write) begin
            lpt_data_o <= bus_i.data;
        end
    end

    // Bit 7 gates NMI, the rest is kept readable
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            nmi_mask_o <= NMI_RESET;
        end
        else if (nmi_write) begin
            nmi_mask_o <= bus_i.data;
        end
    end

endmodule

//--- hdl/read_mux.sv
/*
 * Read-back data mux
 * Fixed-priority selection of the read source, registered onto
 * the chipset data bus with its valid flag
 */
`timescale 1ns/1ps

module read_mux
    import xt_io_pkg::*;
(
    input  logic                     clock,
    input  logic                     reset,
    input  bus_req_t                 bus_i,
    input  dev_sel_t                 sel_i,
    input  logic                     interrupt_acknowledge_n_i,
    input  logic [DATA_W-1:0]        pic_data_i,
    input  logic [DATA_W-1:0]        pit_data_i,
    input  logic [DATA_W-1:0]        ppi_data_i,
    input  ems_map_t [EMS_PAGES-1:0] maps_i,
    input  logic [DATA_W-1:0]        lpt_data_i,
    input  logic [DATA_W-1:0]        nmi_mask_i,
    output logic [DATA_W-1:0]        data_bus_out_o,
    output logic                     data_out_valid_o
);

    read_src_e         src;
    ems_map_t          ems_entry;
    logic [DATA_W-1:0] ems_byte;
    logic [DATA_W-1:0] rd_byte;
    logic              rd;

    assign rd = ~bus_i.io_read_n;

    // INTA wins even without a read strobe
    always_comb begin
        if (~interrupt_acknowledge_n_i) src = SRC_INTA;
        else if (rd && sel_i.pic)       src = SRC_PIC;
        else if (rd && sel_i.pit)       src = SRC_PIT;
        else if (rd && sel_i.ppi)       src = SRC_PPI;
        else if (rd && sel_i.ems)       src = SRC_EMS;
        else if (rd && sel_i.lpt)       src = SRC_LPT;
        else if (rd && sel_i.nmi_mask)  src = SRC_NMI;
        else                            src = SRC_NONE;
    end

    assign ems_entry = maps_i[bus_i.address[1:0]];
    assign ems_byte  = ems_entry.enable ? {1'b0, ems_entry.page} : IDLE_BYTE;

    always_comb begin
        case (src)
            SRC_INTA, SRC_PIC: rd_byte = pic_data_i;
            SRC_PIT:           rd_byte = pit_data_i;
            SRC_PPI:           rd_byte = ppi_data_i;
            SRC_EMS:           rd_byte = ems_byte;
            SRC_LPT:           rd_byte = lpt_data_i;
            SRC_NMI:           rd_byte = nmi_mask_i;
            default:           rd_byte = '0;
        endcase
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            data_bus_out_o   <= '0;
            data_out_valid_o <= 1'b0;
        end
        else begin
            data_bus_out_o   <= rd_byte;
            data_out_valid_o <= (src != SRC_NONE);
        end
    end

endmodule

//--- hdl/xt_io_pkg.sv
/*
 * XT I/O glue shared definitions
 * Port map constants, EMS frame prefixes, bus and select structs,
 * and the EMS write action and read-back source encodings
 */
package xt_io_pkg;

    localparam int ADDR_W    = 20;
    localparam int DATA_W    = 8;
    localparam int EMS_PAGES = 4;
    localparam int EMS_MAP_W = 7;

    // ISA port addresses, compared on address[15:0]
    localparam logic [15:0] EMS_PORT_BASE = 16'h0260;
    localparam logic [15:0] LPT_PORT      = 16'h0378;
    localparam logic [15:0] NMI_PORT_BASE = 16'h00A0;

    // Upper nibble of the 64 KB EMS page frame
    localparam logic [3:0] EMS_FRAME_A = 4'b1010;
    localparam logic [3:0] EMS_FRAME_C = 4'b1100;
    localparam logic [3:0] EMS_FRAME_D = 4'b1101;

    localparam logic [DATA_W-1:0] LPT_RESET = 8'hFF;
    localparam logic [DATA_W-1:0] NMI_RESET = 8'hFF;

    // Unmapped read value, also the write byte that unmaps a page
    localparam logic [DATA_W-1:0] IDLE_BYTE = 8'hFF;

    typedef struct packed {
        logic [ADDR_W-1:0] address;
        logic [DATA_W-1:0] data;
        logic              io_read_n;
        logic              io_write_n;
        logic              address_enable_n;
    } bus_req_t;

    typedef struct packed {
        logic pic;
        logic pit;
        logic ppi;
        logic ems;
        logic lpt;
        logic nmi_mask;
    } dev_sel_t;

    typedef struct packed {
        logic                 enable;
        logic [EMS_MAP_W-1:0] page;
    } ems_map_t;

    typedef enum logic [1:0] {
        EMS_KEEP,
        EMS_MAP,
        EMS_UNMAP
    } ems_action_e;

    typedef enum logic [2:0] {
        SRC_NONE,
        SRC_INTA,
        SRC_PIC,
        SRC_PIT,
        SRC_PPI,
        SRC_EMS,
        SRC_LPT,
        SRC_NMI
    } read_src_e;

endpackage

//--- hdl/xt_io_top.sv
/*
 * XT peripheral board I/O glue
 * Port decode, EMS mapper, port latches and read-back bus
 */
`timescale 1ns/1ps

module xt_io_top
    import xt_io_pkg::*;
(
    input  logic                 clock,
    input  logic                 reset,
    input  bus_req_t             bus_i,
    input  logic                 interrupt_acknowledge_n_i,
    input  logic                 tandy_video_i,
    input  logic                 ems_enabled_i,
    input  logic [1:0]           ems_frame_i,
    input  logic [DATA_W-1:0]    pic_data_i,
    input  logic [DATA_W-1:0]    pit_data_i,
    input  logic [DATA_W-1:0]    ppi_data_i,
    output logic                 dma_cs_n_o,
    output logic                 dma_page_cs_n_o,
    output logic                 pic_cs_n_o,
    output logic                 pit_cs_n_o,
    output logic                 ppi_cs_n_o,
    output logic [EMS_PAGES-1:0] ems_hit_o,
    output logic [DATA_W-1:0]    data_bus_out_o,
    output logic                 data_out_valid_o
);

    dev_sel_t                 sel;
    ems_map_t [EMS_PAGES-1:0] maps;
    logic [DATA_W-1:0]        lpt_data;
    logic [DATA_W-1:0]        nmi_mask_data;

    io_decode i_decode (
        .bus_i           (bus_i),
        .ems_enabled_i   (ems_enabled_i),
        .tandy_video_i   (tandy_video_i),
        .sel_o           (sel),
        .dma_cs_n_o      (dma_cs_n_o),
        .dma_page_cs_n_o (dma_page_cs_n_o),
        .pic_cs_n_o      (pic_cs_n_o),
        .pit_cs_n_o      (pit_cs_n_o),
        .ppi_cs_n_o      (ppi_cs_n_o)
    );

    ems_mapper i_ems (
        .clock       (clock),
        .reset       (reset),
        .bus_i       (bus_i),
        .sel_i       (sel),
        .ems_frame_i (ems_frame_i),
        .maps_o      (maps),
        .ems_hit_o   (ems_hit_o)
    );

    port_latches i_latches (
        .clock      (clock),
        .reset      (reset),
        .bus_i      (bus_i),
        .sel_i      (sel),
        .lpt_data_o (lpt_data),
        .nmi_mask_o (nmi_mask_data)
    );

    read_mux i_read (
        .clock                     (clock),
        .reset                     (reset),
        .bus_i                     (bus_i),
        .sel_i                     (sel),
        .interrupt_acknowledge_n_i (interrupt_acknowledge_n_i),
        .pic_data_i                (pic_data_i),
        .pit_data_i                (pit_data_i),
        .ppi_data_i                (ppi_data_i),
        .maps_i                    (maps),
        .lpt_data_i                (lpt_data),
        .nmi_mask_i                (nmi_mask_data),
        .data_bus_out_o            (data_bus_out_o),
        .data_out_valid_o          (data_out_valid_o)
    );

endmodule

//--- project.f
+incdir+hdl
hdl/xt_io_pkg.sv
hdl/io_decode.sv
hdl/ems_mapper.sv
hdl/port_latches.sv
hdl/read_mux.sv
hdl/xt_io_top.sv
sim/xt_io_properties.sv
sim/tb_xt_io.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the XT I/O glue testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f project.f --top-module tb_xt_io -Mdir "$OBJ" -o tb_xt_io
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/tb_xt_io" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q '^\*\* PASS \*\*$' "$LOG"; then
    echo "Result: passed"
    exit 0
else
    echo "Result: failed"
    exit 1
fi

//--- sim/tb_xt_io.sv
/*
 * Testbench for the XT I/O glue
 * Applies a table of bus operations and checks chip selects,
 * EMS window hits and read-back data against a reference model
 */
`timescale 1ns/1ps

module tb_xt_io
    import xt_io_pkg::*;
();

    typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_MEM, OP_INTA} op_e;

    typedef struct packed {
        op_e         op;
        logic [19:0] address;
        logic [7:0]  data;
        logic        aen_n;
        logic        tandy;
        logic        ems_en;
        logic [1:0]  frame;
        logic [4:0]  cs_n;
        logic        valid;
    } step_t;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_STEPS    = 48;

    // {dma, dma_page, pic, pit, ppi}, active low
    localparam logic [4:0] CS_NONE = 5'b11111;
    localparam logic [4:0] CS_DMA  = 5'b01111;
    localparam logic [4:0] CS_PAGE = 5'b10111;
    localparam logic [4:0] CS_PIC  = 5'b11011;
    localparam logic [4:0] CS_PIT  = 5'b11101;
    localparam logic [4:0] CS_PPI  = 5'b11110;

    // Mode bits {aen_n, tandy, ems_en, frame[1:0]}
    localparam logic [4:0] M_PLAIN = 5'b00000;
    localparam logic [4:0] M_NOAEN = 5'b10000;
    localparam logic [4:0] M_TANDY = 5'b01000;
    localparam logic [4:0] M_EMS   = 5'b00100;

    logic              clock;
    logic              reset;
    bus_req_t          bus;
    logic              inta_n;
    logic              tandy;
    logic              ems_en;
    logic [1:0]        frame;
    logic [7:0]        pic_data;
    logic [7:0]        pit_data;
    logic [7:0]        ppi_data;
    logic              dma_cs_n;
    logic              dma_page_cs_n;
    logic              pic_cs_n;
    logic              pit_cs_n;
    logic              ppi_cs_n;
    logic [3:0]        ems_hit;
    logic [7:0]        data_out;
    logic              data_valid;

    step_t             steps [NUM_STEPS];
    int                n_steps;
    int                cur_step;
    integer            seed;
    ems_map_t          ems_ref [4];
    logic [7:0]        lpt_ref;
    logic [7:0]        nmi_ref;

    xt_io_top i_dut (
        .clock                     (clock),
        .reset                     (reset),
        .bus_i                     (bus),
        .interrupt_acknowledge_n_i (inta_n),
        .tandy_video_i             (tandy),
        .ems_enabled_i             (ems_en),
        .ems_frame_i               (frame),
        .pic_data_i                (pic_data),
        .pit_data_i                (pit_data),
        .ppi_data_i                (ppi_data),
        .dma_cs_n_o                (dma_cs_n),
        .dma_page_cs_n_o           (dma_page_cs_n),
        .pic_cs_n_o                (pic_cs_n),
        .pit_cs_n_o                (pit_cs_n),
        .ppi_cs_n_o                (ppi_cs_n),
        .ems_hit_o                 (ems_hit),
        .data_bus_out_o            (data_out),
        .data_out_valid_o          (data_valid)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("mismatch %s at step %0d: got %0h, expected %0h",
                     name, cur_step, actual, expected);
            $display("** FAIL **");
            $fatal(1, "check failed");
        end
    endtask

    task automatic add_step(input op_e op, input logic [19:0] address, input logic [7:0] data,
                            input logic [4:0] mode, input logic [4:0] cs_n, input logic valid);
        step_t s;
        s.op      = op;
        s.address = address;
        s.data    = data;
        s.aen_n   = mode[4];
        s.tandy   = mode[3];
        s.ems_en  = mode[2];
        s.frame   = mode[1:0];
        s.cs_n    = cs_n;
        s.valid   = valid;
        if (n_steps < NUM_STEPS) begin
            steps[n_steps] = s;
        end
        n_steps++;
    endtask

    task automatic build_table();
        // Chip selects and PIC/PIT/PPI read-back
        add_step(OP_READ,  20'h00000, 8'h00, M_PLAIN, CS_DMA,  1'b0);
        add_step(OP_READ,  20'h00020, 8'h00, M_PLAIN, CS_PIC,  1'b1);
        add_step(OP_READ,  20'h00040, 8'h00, M_PLAIN, CS_PIT,  1'b1);
        add_step(OP_READ,  20'h00061, 8'h00, M_PLAIN, CS_PPI,  1'b1);
        add_step(OP_READ,  20'h00081, 8'h00, M_PLAIN, CS_PAGE, 1'b0);
        add_step(OP_WRITE, 20'h00020, 8'h00, M_NOAEN, CS_NONE, 1'b0);
        add_step(OP_READ,  20'h00040, 8'h00, M_NOAEN, CS_NONE, 1'b0);
        add_step(OP_INTA,  20'h00000, 8'h00, M_PLAIN, CS_NONE, 1'b1);
        add_step(OP_READ,  20'h00120, 8'h00, M_PLAIN, CS_NONE, 1'b0);
        // LPT and NMI mask latches
        add_step(OP_READ,  20'h00378, 8'h00, M_PLAIN, CS_NONE, 1'b1);
        add_step(OP_READ,  20'h000A0, 8'h00, M_TANDY, CS_NONE, 1'b1);
        add_step(OP_WRITE, 20'h00378, 8'h5A, M_PLAIN, CS_NONE, 1'b0);
        add_step(OP_READ,  20'h00378, 8'h00, M_PLAIN, CS_NONE, 1'b1);
        add_step(OP_WRITE, 20'h000A3, 8'h3C, M_TANDY, CS_NONE, 1'b0);
        add_step(OP_READ,  20'h000A7, 8'h00, M_TANDY, CS_NONE, 1'b1);
        add_step(OP_READ,  20'h000A7, 8'h00, M_PLAIN, CS_NONE, 1'b0);
        add_step(OP_WRITE, 20'h000A0, 8'h11, M_PLAIN, CS_NONE, 1'b0);
        add_step(OP_READ,  20'h000A0, 8'h00, M_TANDY, CS_NONE, 1'b1);
        // EMS page maps
        add_step(OP_READ,  20'h00260, 8'h00, M_PLAIN, CS_NONE, 1'b0);
        add_step(OP_READ,  20'h00260, 8'h00, M_EMS,   CS_NONE, 1'b1);
        add_step(OP_WRITE, 20'h00260, 8'h05, M_EMS,   CS_NONE, 1'b0);
        add_step(OP_WRITE, 20'h00261, 8'h7F, M_EMS,   CS_NONE, 1'b0);
        add_step(OP_WRITE, 20'h00262, 8'h40, M_EMS,   CS_NONE, 1'b0);
        add_step(OP_READ,  20'h00260, 8'h00, M_EMS,   CS_NONE, 1'b1);
        add_step(OP_READ,  20'h00261, 8'h00, M_EMS,   CS_NONE, 1'b1);
        add_step(OP_READ,  20'h00262, 8'h00, M_EMS,   CS_NONE, 1'b1);
        add_step(OP_READ,  20'h00263, 8'h00, M_EMS,   CS_NONE, 1'b1);
        add_step(OP_WRITE, 20'h00261, 8'h80, M_EMS,   CS_NONE, 1'b0);
        add_step(OP_READ,  20'h00261, 8'h00, M_EMS,   CS_NONE, 1'b1);
        add_step(OP_WRITE, 20'h00262, 8'hFE, M_EMS,   CS_NONE, 1'b0);
        add_step(OP_READ,  20'h00262, 8'h00, M_EMS,   CS_NONE, 1'b1);
        add_step(OP_WRITE, 20'h00262, 8'hFF, M_EMS,   CS_NONE, 1'b0);
        add_step(OP_READ,  20'h00262, 8'h00, M_EMS,   CS_NONE, 1'b1);
        add_step(OP_WRITE, 20'h00263, 8'h00, M_PLAIN, CS_NONE, 1'b0);
        add_step(OP_READ,  20'h00263, 8'h00, M_EMS,   CS_NONE, 1'b1);
        add_step(OP_WRITE, 20'h00263, 8'h12, M_EMS,   CS_NONE, 1'b0);
        // Memory window probes for each frame
        add_step(OP_MEM,   20'hA0010, 8'h00, M_EMS,         CS_NONE, 1'b0);
        add_step(OP_MEM,   20'hA4000, 8'h00, M_EMS,         CS_NONE, 1'b0);
        add_step(OP_MEM,   20'hA8000, 8'h00, M_EMS,         CS_NONE, 1'b0);
        add_step(OP_MEM,   20'hAFFFF, 8'h00, M_EMS,         CS_NONE, 1'b0);
        add_step(OP_MEM,   20'hC4123, 8'h00, M_EMS | 5'd1, CS_NONE, 1'b0);
        add_step(OP_MEM,   20'hCC000, 8'h00, M_EMS | 5'd1, CS_NONE, 1'b0);
        add_step(OP_MEM,   20'hA0000, 8'h00, M_EMS | 5'd1, CS_NONE, 1'b0);
        add_step(OP_MEM,   20'hD0000, 8'h00, M_EMS | 5'd2, CS_NONE, 1'b0);
        add_step(OP_MEM,   20'hD8000, 8'h00, M_EMS | 5'd2, CS_NONE, 1'b0);
        add_step(OP_MEM,   20'hDC000, 8'h00, M_EMS | 5'd3, CS_NONE, 1'b0);
        add_step(OP_MEM,   20'hD4000, 8'h00, M_EMS | 5'd3, CS_NONE, 1'b0);
        add_step(OP_READ,  20'h00378, 8'h00, M_EMS | 5'd3, CS_NONE, 1'b1);
    endtask

    function automatic logic [3:0] frame_prefix(input logic [1:0] f);
        case (f)
            2'd0:    return 4'b1010;
            2'd1:    return 4'b1100;
            default: return 4'b1101;
        endcase
    endfunction

    // Reference model of the read-back byte, by fixed priority
    function automatic logic [7:0] expected_data(input step_t s);
        logic [15:0] port;
        port = s.address[15:0];
        if (s.op == OP_INTA) return pic_data;
        if (s.op != OP_READ || s.aen_n) return 8'h00;
        if (port[9:8] == 2'b00 && port[7:5] == 3'd1) return pic_data;
        if (port[9:8] == 2'b00 && port[7:5] == 3'd2) return pit_data;
        if (port[9:8] == 2'b00 && port[7:5] == 3'd3) return ppi_data;
        if (s.ems_en && port[15:2] == 14'h0098) begin
            if (ems_ref[port[1:0]].enable) return {1'b0, ems_ref[port[1:0]].page};
            return 8'hFF;
        end
        if (port == 16'h0378) return lpt_ref;
        if (s.tandy && port[15:3] == 13'h0014) return nmi_ref;
        return 8'h00;
    endfunction

    function automatic logic [3:0] expected_hit(input step_t s);
        logic [3:0] hit;
        hit = '0;
        for (int n = 0; n < 4; n++) begin
            if (ems_ref[n].enable && s.address[19:14] == {frame_prefix(s.frame), 2'(n)}) begin
                hit[n] = 1'b1;
            end
        end
        return hit;
    endfunction

    task automatic update_model(input step_t s);
        logic [15:0] port;
        port = s.address[15:0];
        if (s.op == OP_WRITE && !s.aen_n) begin
            if (s.ems_en && port[15:2] == 14'h0098) begin
                if (s.data == 8'hFF) begin
                    ems_ref[port[1:0]] = '{enable: 1'b0, page: 7'h7F};
                end
                else if (s.data < 8'h80) begin
                    ems_ref[port[1:0]] = '{enable: 1'b1, page: s.data[6:0]};
                end
            end
            if (port == 16'h0378) begin
                lpt_ref = s.data;
            end
            if (s.tandy && port[15:3] == 13'h0014) begin
                nmi_ref = s.data;
            end
        end
    endtask

    task automatic drive_idle();
        bus.io_read_n        = 1'b1;
        bus.io_write_n       = 1'b1;
        bus.address_enable_n = 1'b1;
        inta_n               = 1'b1;
    endtask

    task automatic drive_step(input step_t s);
        logic [31:0] rnd;
        rnd                  = $random(seed);
        pic_data             = rnd[7:0];
        pit_data             = rnd[7:0] ^ 8'h5A;
        ppi_data             = rnd[7:0] ^ 8'hA5;
        bus.address          = s.address;
        bus.data             = s.data;
        bus.address_enable_n = s.aen_n;
        bus.io_read_n        = (s.op != OP_READ);
        bus.io_write_n       = (s.op != OP_WRITE);
        inta_n               = (s.op != OP_INTA);
        tandy                = s.tandy;
        ems_en               = s.ems_en;
        frame                = s.frame;
    endtask

    // One strobe cycle, then three idle cycles
    task automatic run_step(input step_t s);
        logic [7:0] exp_data;
        @(negedge clock);
        drive_step(s);
        #1;
        check_value("chip_selects_n",
                    32'({dma_cs_n, dma_page_cs_n, pic_cs_n, pit_cs_n, ppi_cs_n}), 32'(s.cs_n));
        if (s.op == OP_MEM) begin
            check_value("ems_hit_o", 32'(ems_hit), 32'(expected_hit(s)));
        end
        exp_data = expected_data(s);
        @(negedge clock);
        check_value("data_out_valid_o", 32'(data_valid), 32'(s.valid));
        check_value("data_bus_out_o", 32'(data_out), 32'(exp_data));
        update_model(s);
        drive_idle();
        repeat (2) @(negedge clock);
        check_value("data_out_valid_o", 32'(data_valid), 32'd0);
        check_value("data_bus_out_o", 32'(data_out), 32'd0);
    endtask

    initial begin
        clock    = 1'b0;
        reset    = 1'b1;
        bus      = '0;
        drive_idle();
        tandy    = 1'b0;
        ems_en   = 1'b0;
        frame    = 2'd0;
        pic_data = 8'h00;
        pit_data = 8'h00;
        ppi_data = 8'h00;
        seed     = 32'h18b7;
        n_steps  = 0;
        cur_step = -1;
        lpt_ref  = 8'hFF;
        nmi_ref  = 8'hFF;
        for (int n = 0; n < 4; n++) begin
            ems_ref[n] = '0;
        end
        build_table();
        if (n_steps != NUM_STEPS) begin
            $display("Stimulus table holds %0d steps instead of %0d", n_steps, NUM_STEPS);
            $display("** FAIL **");
            $fatal(1, "bad stimulus table");
        end
        repeat (RESET_CYCLES) @(negedge clock);
        reset = 1'b0;
        check_value("data_out_valid_o", 32'(data_valid), 32'd0);
        check_value("data_bus_out_o", 32'(data_out), 32'd0);
        check_value("ems_hit_o", 32'(ems_hit), 32'd0);
        for (int i = 0; i < NUM_STEPS; i++) begin
            cur_step = i;
            run_step(steps[i]);
        end
        $display("** PASS **");
        $finish;
    end

    // Watchdog
    initial begin
        #((NUM_STEPS * 5 + RESET_CYCLES) * CLK_PERIOD);
        $display("Timeout: the run did not complete in the expected time");
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- sim/xt_io_properties.sv
/*
 * XT I/O glue assertions
 * Bound into the top level to watch reset, chip selects and EMS hits
 */
`timescale 1ns/1ps

module xt_io_properties
    import xt_io_pkg::*;
(
    input logic                 clock,
    input logic                 reset,
    input logic                 dma_cs_n_i,
    input logic                 dma_page_cs_n_i,
    input logic                 pic_cs_n_i,
    input logic                 pit_cs_n_i,
    input logic                 ppi_cs_n_i,
    input logic                 ems_enabled_i,
    input logic [EMS_PAGES-1:0] ems_hit_i,
    input logic                 data_out_valid_i
);

    logic ems_seen;

    // Sticky once EMS has been enabled after reset
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            ems_seen <= 1'b0;
        end
        else if (ems_enabled_i) begin
            ems_seen <= 1'b1;
        end
    end

    a_valid_in_reset: assert property (
        @(posedge clock) reset |-> !data_out_valid_i
    ) else $error("data_out_valid_o high during reset");

    a_one_chip_select: assert property (
        @(posedge clock) disable iff (reset)
        $onehot0(~{dma_cs_n_i, dma_page_cs_n_i, pic_cs_n_i, pit_cs_n_i, ppi_cs_n_i})
    ) else $error("more than one chip select active");

    a_no_hit_without_ems: assert property (
        @(posedge clock) disable iff (reset)
        !(ems_seen || ems_enabled_i) |-> (ems_hit_i == '0)
    ) else $error("EMS window hit before EMS was ever enabled");

endmodule

bind xt_io_top xt_io_properties i_props (
    .clock            (clock),
    .reset            (reset),
    .dma_cs_n_i       (dma_cs_n_o),
    .dma_page_cs_n_i  (dma_page_cs_n_o),
    .pic_cs_n_i       (pic_cs_n_o),
    .pit_cs_n_i       (pit_cs_n_o),
    .ppi_cs_n_i       (ppi_cs_n_o),
    .ems_enabled_i    (ems_enabled_i),
    .ems_hit_i        (ems_hit_o),
    .data_out_valid_i (data_out_valid_o)
);
